//--- bench/fetch_cases.txt
# L <byte addr hex> <word hex> load, R <count> <stall percent> run, B <target hex> branch
# T <with branch 0/1> <branch target hex> trap flush, the trap vector always wins
L 00000000 00000013
L 00000004 00a00093
L 00000008 00108113
L 0000000c fe209ee3
L 00000080 34202573
L 00000084 30200073
R 8 0
R 20 30
B 00000040
R 6 0
R 12 50
B 000000f0
R 8 20
T 0 00000000
R 5 0
T 1 00000020
R 6 0
R 10 40

//--- bench/tb_fetch_top.sv
// Testbench for the fetch front end
// Case-file stimulus, reference memory and PC model, typed compare tasks

`timescale 1ns/1ps

module tb_fetch_top;

  import core_pkg::*;
  import icb_pkg::*;

  localparam wait_t MEM_WAIT  = 4'd2;
  localparam int    MEM_WORDS = 64;
  localparam int    TIMEOUT   = 200;  // Cycles allowed per delivery

  logic  clk;
  logic  rstn;
  logic  ctrl_ifu_flush;
  logic  br_ctrl_flush;
  addr_t br_target;
  logic  ctrl_ifu_stall;
  logic  mem_we;
  addr_t mem_waddr;
  word_t mem_wdata;
  word_t ifu_de_ins;
  logic  ifu_de_valid;
  addr_t ifu_alu_current_pc;
  addr_t ifu_ctrl_int_epc;
  logic  ifu_ctrl_valid;

  word_t ref_mem [MEM_WORDS];  // Copy of the program
  addr_t exp_pc;               // PC of the next instruction due
  int    delivered;            // Instructions checked so far
  int    rsp_open;             // Responses returned, not yet delivered

  fetch_top #(.MEM_WAIT(MEM_WAIT), .MEM_WORDS(MEM_WORDS)) i_fetch_top (
    .clk                (clk),
    .rstn               (rstn),
    .ctrl_ifu_flush     (ctrl_ifu_flush),
    .br_ctrl_flush      (br_ctrl_flush),
    .br_target          (br_target),
    .ctrl_ifu_stall     (ctrl_ifu_stall),
    .mem_we             (mem_we),
    .mem_waddr          (mem_waddr),
    .mem_wdata          (mem_wdata),
    .ifu_de_ins         (ifu_de_ins),
    .ifu_de_valid       (ifu_de_valid),
    .ifu_alu_current_pc (ifu_alu_current_pc),
    .ifu_ctrl_int_epc   (ifu_ctrl_int_epc),
    .ifu_ctrl_valid     (ifu_ctrl_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // --------------------------------------------------------------------------
  // Error handling and compares
  // --------------------------------------------------------------------------
  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic expect_fields(input int got, input int want);
    if (got != want) begin
      $display("Malformed record in the case file, %0d of %0d fields read", got, want);
      abort_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // Reference model and stimulus
  // --------------------------------------------------------------------------
  // Word index wraps at the memory depth
  function automatic int mem_index(input addr_t a);
    return (a >> 2) % MEM_WORDS;
  endfunction

  // Background program, every address bit feeds in
  function automatic word_t fill_word(input addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h0f1e_2d3c;
  endfunction

  task automatic write_word(input addr_t a, input word_t d);
    @(posedge clk);
    mem_we    <= 1'b1;
    mem_waddr <= a;
    mem_wdata <= d;
    ref_mem[mem_index(a)] = d;
    @(posedge clk);
    mem_we <= 1'b0;
  endtask

  // One-cycle flush, decode must be empty right after it
  task automatic redirect(input logic trap, input logic branch, input addr_t target);
    @(posedge clk);
    ctrl_ifu_flush <= trap;
    br_ctrl_flush  <= branch;
    br_target      <= target;
    ctrl_ifu_stall <= 1'b0;
    @(posedge clk);
    ctrl_ifu_flush <= 1'b0;
    br_ctrl_flush  <= 1'b0;
    @(negedge clk);
    check_flag("ifu_de_valid", ifu_de_valid, 1'b0);
    exp_pc   = trap ? TRAP_VEC : target;  // Trap wins over branch
    rsp_open = 0;                         // Decode and hold emptied
  endtask

  // Deliver count instructions with random stall, pct in percent
  task automatic run_insns(input int count, input int pct);
    int    got;
    int    idle;       // Cycles since the last delivery
    int    cyc;
    int    last_cyc;
    logic  held;       // Stall seen by the DUT at this edge
    logic  have_prev;
    logic  prev_valid;
    word_t prev_ins;
    addr_t prev_pc;
    got       = 0;
    idle      = 0;
    cyc       = 0;
    last_cyc  = -1;
    have_prev = 1'b0;
    while (got < count) begin
      @(posedge clk);
      held = ctrl_ifu_stall;
      ctrl_ifu_stall <= (($urandom % 100) < pct);
      cyc++;
      @(negedge clk);
      if (held && have_prev) begin  // Decode frozen over a stalled edge
        check_flag("ifu_de_valid", ifu_de_valid, prev_valid);
        check_word("ifu_de_ins", ifu_de_ins, prev_ins);
        check_addr("ifu_alu_current_pc", ifu_alu_current_pc, prev_pc);
      end
      if (ifu_de_valid && !ctrl_ifu_stall) begin  // Taken by decode at next edge
        check_addr("ifu_alu_current_pc", ifu_alu_current_pc, exp_pc);
        check_addr("ifu_ctrl_int_epc", ifu_ctrl_int_epc, exp_pc);
        check_word("ifu_de_ins", ifu_de_ins, ref_mem[mem_index(exp_pc)]);
        if (rsp_open < 1) begin
          $display("No ifu_ctrl_valid pulse before %0t for the instruction at %h",
                   $time, exp_pc);
          abort_run();
        end
        rsp_open--;
        if (pct == 0 && last_cyc >= 0 && cyc - last_cyc != MEM_WAIT + 3) begin
          $display("Mismatch at %0t: ifu_de_valid spacing is %0d, expected %0d",
                   $time, cyc - last_cyc, MEM_WAIT + 3);
          abort_run();
        end
        last_cyc = cyc;
        exp_pc   = exp_pc + 32'd4;
        got++;
        delivered++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          $display("Timeout at %0t: no instruction delivered in %0d cycles", $time, TIMEOUT);
          abort_run();
        end
      end
      // Word back from the bus and kept, at most decode plus hold are full
      if (ifu_ctrl_valid) rsp_open++;
      if (rsp_open > 2) begin
        $display("ifu_ctrl_valid at %0t pulsed with decode and hold register full", $time);
        abort_run();
      end
      prev_valid = ifu_de_valid;
      prev_ins   = ifu_de_ins;
      prev_pc    = ifu_alu_current_pc;
      have_prev  = 1'b1;
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int                 fd;
    int                 r;
    int                 n;
    int                 p;
    logic [7:0]         kind;   // Record letter
    logic [8*256-1:0]   skip;   // Rest of a comment line
    addr_t              a;
    word_t              d;
    void'($urandom(61));
    rstn           = 1'b0;
    ctrl_ifu_flush = 1'b0;
    br_ctrl_flush  = 1'b0;
    br_target      = '0;
    ctrl_ifu_stall = 1'b1;      // No fetch until the program is loaded
    mem_we         = 1'b0;
    mem_waddr      = '0;
    mem_wdata      = '0;
    exp_pc         = RESET_PC;
    delivered      = 0;
    rsp_open       = 0;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      write_word(addr_t'(i * 4), fill_word(addr_t'(i * 4)));
    end
    fd = $fopen("bench/fetch_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file bench/fetch_cases.txt");
      abort_run();
    end
    while ($fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "#": r = $fgets(skip, fd);
        "L": begin
          r = $fscanf(fd, "%h %h", a, d);
          expect_fields(r, 2);
          write_word(a, d);
        end
        "R": begin
          r = $fscanf(fd, "%d %d", n, p);
          expect_fields(r, 2);
          run_insns(n, p);
        end
        "B": begin
          r = $fscanf(fd, "%h", a);
          expect_fields(r, 1);
          redirect(1'b0, 1'b1, a);
        end
        "T": begin
          r = $fscanf(fd, "%d %h", n, a);
          expect_fields(r, 2);
          redirect(1'b1, n != 0, a);  // Optional branch in the same cycle
        end
        default: begin
          $display("Unknown record type '%c' in the case file", kind);
          abort_run();
        end
      endcase
    end
    $fclose(fd);
    if (delivered > 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("The case file delivered no instructions");
      abort_run();
    end
  end

endmodule

//--- sim.f
source/core_pkg.sv
source/icb_pkg.sv
source/pc_gen.sv
source/ifu.sv
source/biu_ctrl.sv
source/wait_timer.sv
source/imem.sv
source/fetch_top.sv
bench/tb_fetch_top.sv

//--- source/biu_ctrl.sv
// Bus interface unit control
// Command accept, wait-state sequencing and one-cycle response

`timescale 1ns/1ps

module biu_ctrl (
  input  logic            clk,
  input  logic            rstn,
  input  logic            cmd_valid,
  input  core_pkg::addr_t cmd_addr,
  output logic            cmd_ready,    // High only when idle
  output logic            timer_start,  // Pulse on accept
  input  logic            timer_done,
  output core_pkg::addr_t mem_addr,     // Latched fetch address
  input  core_pkg::word_t mem_rdata,
  output logic            rsp_valid,
  output core_pkg::word_t rsp_rdata
);

  import icb_pkg::*;

  biu_state_t state;
  biu_state_t state_nxt;
  logic       cmd_acc;  // Handshake completes

  assign cmd_ready   = (state == BIU_IDLE);
  assign cmd_acc     = cmd_valid & cmd_ready;
  assign timer_start = cmd_acc;

  // -------------------------------------------------------------------------
  // State machine
  // -------------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    unique case (state)
      BIU_IDLE: if (cmd_acc) state_nxt = BIU_WAIT;
      BIU_WAIT: if (timer_done) state_nxt = BIU_RESP;  // Memory word settled
      BIU_RESP: state_nxt = BIU_IDLE;                  // Single beat only
      default:  state_nxt = BIU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= BIU_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Address held for the whole access
  always_ff @(posedge clk) begin
    if (cmd_acc) mem_addr <= cmd_addr;
  end

  // Response beat
  assign rsp_valid = (state == BIU_RESP);
  assign rsp_rdata = mem_rdata;  // Combinational RAM read

  // -------------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------------
  // The timer only finishes an access that is being waited for
  a_done_in_wait : assert property (
    @(posedge clk) disable iff (!rstn)
    timer_done |-> state == BIU_WAIT
  ) else $error("biu_ctrl: timer done outside the wait state");

endmodule

//--- source/core_pkg.sv
// Core-side definitions for the fetch front end
// Word and address types, reset and trap vectors, instruction step

package core_pkg;

  // -------------------------------------------------------------------------
  // Data path widths
  // -------------------------------------------------------------------------
  typedef logic [31:0] word_t;  // Instruction or data word
  typedef logic [31:0] addr_t;  // Byte address

  // -------------------------------------------------------------------------
  // Fixed addresses and the sequential step
  // -------------------------------------------------------------------------
  localparam addr_t RESET_PC    = 32'h0000_0000;  // First fetch after reset
  localparam addr_t TRAP_VEC    = 32'h0000_0080;  // Target of a trap flush
  localparam addr_t INSTR_BYTES = 32'd4;          // One 32-bit instruction

endpackage

//--- source/fetch_top.sv
// Fetch front-end top level
// Connects pc_gen, ifu, biu_ctrl, wait_timer and imem

`timescale 1ns/1ps

module fetch_top #(
  parameter icb_pkg::wait_t MEM_WAIT  = 4'd2,
  parameter int             MEM_WORDS = 64
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            ctrl_ifu_flush,
  input  logic            br_ctrl_flush,
  input  core_pkg::addr_t br_target,
  input  logic            ctrl_ifu_stall,
  input  logic            mem_we,
  input  core_pkg::addr_t mem_waddr,
  input  core_pkg::word_t mem_wdata,
  output core_pkg::word_t ifu_de_ins,
  output logic            ifu_de_valid,
  output core_pkg::addr_t ifu_alu_current_pc,
  output core_pkg::addr_t ifu_ctrl_int_epc,
  output logic            ifu_ctrl_valid
);

  import core_pkg::*;

  // -------------------------------------------------------------------------
  // Internal nets
  // -------------------------------------------------------------------------
  addr_t pc_ifu_addr;
  logic  ifu_pc_icb_cmd_ready;
  logic  ifu_biu_icb_cmd_valid;
  addr_t ifu_biu_icb_cmd_addr;
  logic  biu_ifu_icb_cmd_ready;
  logic  biu_ifu_icb_rsp_valid;
  word_t biu_ifu_icb_rsp_rdata;
  logic  timer_start;
  logic  timer_done;
  addr_t mem_addr;
  word_t mem_rdata;

  pc_gen i_pc_gen (
    .clk                  (clk),
    .rstn                 (rstn),
    .ctrl_ifu_flush       (ctrl_ifu_flush),
    .br_ctrl_flush        (br_ctrl_flush),
    .br_target            (br_target),
    .ifu_pc_icb_cmd_ready (ifu_pc_icb_cmd_ready),
    .pc_ifu_addr          (pc_ifu_addr)
  );

  // Read strobe and rsp_ready are constant, the BIU has no use for them
  ifu i_ifu (
    .clk                   (clk),
    .rstn                  (rstn),
    .ctrl_ifu_flush        (ctrl_ifu_flush),
    .br_ctrl_flush         (br_ctrl_flush),
    .ctrl_ifu_stall        (ctrl_ifu_stall),
    .pc_ifu_addr           (pc_ifu_addr),
    .ifu_pc_icb_cmd_ready  (ifu_pc_icb_cmd_ready),
    .biu_ifu_icb_cmd_ready (biu_ifu_icb_cmd_ready),
    .biu_ifu_icb_rsp_valid (biu_ifu_icb_rsp_valid),
    .biu_ifu_icb_rsp_rdata (biu_ifu_icb_rsp_rdata),
    .ifu_biu_icb_cmd_valid (ifu_biu_icb_cmd_valid),
    .ifu_biu_icb_cmd_addr  (ifu_biu_icb_cmd_addr),
    .ifu_biu_icb_cmd_read  (),
    .ifu_biu_icb_rsp_ready (),
    .ifu_de_ins            (ifu_de_ins),
    .ifu_de_valid          (ifu_de_valid),
    .ifu_alu_current_pc    (ifu_alu_current_pc),
    .ifu_ctrl_int_epc      (ifu_ctrl_int_epc),
    .ifu_ctrl_valid        (ifu_ctrl_valid)
  );

  biu_ctrl i_biu_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_valid   (ifu_biu_icb_cmd_valid),
    .cmd_addr    (ifu_biu_icb_cmd_addr),
    .cmd_ready   (biu_ifu_icb_cmd_ready),
    .timer_start (timer_start),
    .timer_done  (timer_done),
    .mem_addr    (mem_addr),
    .mem_rdata   (mem_rdata),
    .rsp_valid   (biu_ifu_icb_rsp_valid),
    .rsp_rdata   (biu_ifu_icb_rsp_rdata)
  );

  wait_timer #(.MEM_WAIT(MEM_WAIT)) i_wait_timer (
    .clk         (clk),
    .rstn        (rstn),
    .timer_start (timer_start),
    .timer_done  (timer_done)
  );

  imem #(.MEM_WORDS(MEM_WORDS)) i_imem (
    .clk       (clk),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata),
    .mem_we    (mem_we),     // Loader port straight from the pins
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata)
  );

endmodule

//--- source/icb_pkg.sv
// Bus-side definitions for the instruction bus
// BIU state encoding and the wait-state count type

package icb_pkg;

  // BIU sequencing, one fetch in flight at most
  typedef enum logic [1:0] {
    BIU_IDLE = 2'b00,  // Ready for a command
    BIU_WAIT = 2'b01,  // Memory wait states running
    BIU_RESP = 2'b10   // Read word presented for one cycle
  } biu_state_t;

  // Memory wait states, 0 to 15
  typedef logic [3:0] wait_t;

endpackage

//--- source/ifu.sv
// Instruction fetch unit
// Bus command issue, pending fetch PC, hold register, stall and flush
// of the decode pipeline register

`timescale 1ns/1ps

module ifu (
  input  logic            clk,
  input  logic            rstn,
  input  logic            ctrl_ifu_flush,         // Trap flush
  input  logic            br_ctrl_flush,          // Branch flush
  input  logic            ctrl_ifu_stall,         // Back-pressure from decode
  input  core_pkg::addr_t pc_ifu_addr,
  output logic            ifu_pc_icb_cmd_ready,   // Tells pc_gen to step
  input  logic            biu_ifu_icb_cmd_ready,
  input  logic            biu_ifu_icb_rsp_valid,
  input  core_pkg::word_t biu_ifu_icb_rsp_rdata,
  output logic            ifu_biu_icb_cmd_valid,
  output core_pkg::addr_t ifu_biu_icb_cmd_addr,
  output logic            ifu_biu_icb_cmd_read,
  output logic            ifu_biu_icb_rsp_ready,
  output core_pkg::word_t ifu_de_ins,
  output logic            ifu_de_valid,
  output core_pkg::addr_t ifu_alu_current_pc,
  output core_pkg::addr_t ifu_ctrl_int_epc,
  output logic            ifu_ctrl_valid
);

  import core_pkg::*;

  logic  flush;        // Either flush source
  logic  cmd_fire;     // Command accepted this cycle
  logic  rsp_take;     // Response that is not marked dropped
  logic  outstanding;  // One fetch on the bus
  logic  drop;         // In-flight fetch belongs to a flushed path
  addr_t pend_pc;      // PC of the fetch on the bus
  logic  hold_valid;   // Response parked during a stall
  word_t hold_ins;
  addr_t hold_pc;

  // -------------------------------------------------------------------------
  // Bus side
  // -------------------------------------------------------------------------
  assign flush    = ctrl_ifu_flush | br_ctrl_flush;
  assign rsp_take = biu_ifu_icb_rsp_valid & ~drop;

  // Issue only into an empty pipe
  assign ifu_biu_icb_cmd_valid = ~ctrl_ifu_stall & ~flush & ~outstanding & ~hold_valid;
  assign ifu_biu_icb_cmd_addr  = pc_ifu_addr;
  assign ifu_biu_icb_cmd_read  = 1'b1;   // Instruction bus only reads
  assign ifu_biu_icb_rsp_ready = 1'b1;   // Response never refused
  assign cmd_fire              = ifu_biu_icb_cmd_valid & biu_ifu_icb_cmd_ready;
  assign ifu_pc_icb_cmd_ready  = cmd_fire;
  assign ifu_ctrl_valid        = rsp_take;

  // Outstanding and drop flags
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      outstanding <= 1'b0;
      drop        <= 1'b0;
    end else if (cmd_fire) begin
      outstanding <= 1'b1;
      drop        <= 1'b0;
    end else if (biu_ifu_icb_rsp_valid) begin
      outstanding <= 1'b0;  // Fetch retired, kept or dropped
      drop        <= 1'b0;
    end else if (flush && outstanding) begin
      drop <= 1'b1;          // Word still on its way from the old path
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire) pend_pc <= pc_ifu_addr;  // Travels with the word
  end

  // -------------------------------------------------------------------------
  // Hold register
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      hold_valid <= 1'b0;
    end else if (flush || !ctrl_ifu_stall) begin
      hold_valid <= 1'b0;    // Emptied by flush or drained to decode
    end else if (rsp_take) begin
      hold_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_ifu_stall && rsp_take) begin
      hold_ins <= biu_ifu_icb_rsp_rdata;
      hold_pc  <= pend_pc;
    end
  end

  // -------------------------------------------------------------------------
  // Decode pipeline register
  // -------------------------------------------------------------------------
  // Valid holds with the data during a stall, the word is consumed unstalled
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ifu_de_valid       <= 1'b0;
      ifu_de_ins         <= '0;
      ifu_alu_current_pc <= '0;
      ifu_ctrl_int_epc   <= '0;
    end else if (flush) begin
      ifu_de_valid       <= 1'b0;
      ifu_de_ins         <= '0;
      ifu_alu_current_pc <= '0;
      ifu_ctrl_int_epc   <= '0;
    end else if (!ctrl_ifu_stall) begin
      ifu_de_valid <= hold_valid | rsp_take;
      if (hold_valid) begin                  // Parked word goes first
        ifu_de_ins         <= hold_ins;
        ifu_alu_current_pc <= hold_pc;
        ifu_ctrl_int_epc   <= hold_pc;
      end else if (rsp_take) begin
        ifu_de_ins         <= biu_ifu_icb_rsp_rdata;
        ifu_alu_current_pc <= pend_pc;
        ifu_ctrl_int_epc   <= pend_pc;
      end
    end
  end

  // A response always answers a fetch issued earlier by this unit
  a_rsp_has_fetch : assert property (
    @(posedge clk) disable iff (!rstn)
    biu_ifu_icb_rsp_valid |-> outstanding
  ) else $error("ifu: response without an outstanding fetch");

endmodule

//--- source/imem.sv
// Instruction memory
// Word RAM with combinational read for the BIU and a load port

`timescale 1ns/1ps

module imem #(
  parameter int MEM_WORDS = 64  // Depth, power of two
) (
  input  logic            clk,
  input  core_pkg::addr_t mem_addr,   // Byte address, read side
  output core_pkg::word_t mem_rdata,
  input  logic            mem_we,     // Program load
  input  core_pkg::addr_t mem_waddr,
  input  core_pkg::word_t mem_wdata
);

  import core_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  word_t             mem [MEM_WORDS];
  logic [IDX_W-1:0]  rd_idx;  // Word index, wraps at the depth
  logic [IDX_W-1:0]  wr_idx;

  assign rd_idx = mem_addr[2 +: IDX_W];
  assign wr_idx = mem_waddr[2 +: IDX_W];

  // Synchronous write
  always_ff @(posedge clk) begin
    if (mem_we) mem[wr_idx] <= mem_wdata;
  end

  // Read is available in the same cycle
  assign mem_rdata = mem[rd_idx];

endmodule

//--- source/pc_gen.sv
// PC generator for the fetch front end
// Next fetch address with sequential step and flush redirect

`timescale 1ns/1ps

module pc_gen (
  input  logic            clk,
  input  logic            rstn,
  input  logic            ctrl_ifu_flush,        // Trap redirect
  input  logic            br_ctrl_flush,         // Branch redirect
  input  core_pkg::addr_t br_target,
  input  logic            ifu_pc_icb_cmd_ready,  // Pulse per accepted fetch
  output core_pkg::addr_t pc_ifu_addr
);

  import core_pkg::*;

  addr_t pc_nxt;  // Address for the next edge

  // -------------------------------------------------------------------------
  // Next address select
  // -------------------------------------------------------------------------
  // Trap wins over branch, and any redirect wins over the step
  always_comb begin
    pc_nxt = pc_ifu_addr;
    if (ctrl_ifu_flush) begin
      pc_nxt = TRAP_VEC;
    end else if (br_ctrl_flush) begin
      pc_nxt = br_target;
    end else if (ifu_pc_icb_cmd_ready) begin
      pc_nxt = pc_ifu_addr + INSTR_BYTES;  // Fetch went out, move on
    end
  end

  // PC register
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc_ifu_addr <= RESET_PC;
    end else begin
      pc_ifu_addr <= pc_nxt;
    end
  end

  // -------------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------------
  // Branch targets from outside must keep the fetch address on a word
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (!rstn)
    pc_ifu_addr[1:0] == 2'b00
  ) else $error("pc_gen: fetch address not word aligned");

endmodule

//--- source/wait_timer.sv
// Wait-state timer for the instruction memory
// Down counter loaded on start, one done pulse per start

`timescale 1ns/1ps

module wait_timer #(
  parameter icb_pkg::wait_t MEM_WAIT = 4'd2  // Wait states per access
) (
  input  logic clk,
  input  logic rstn,
  input  logic timer_start,
  output logic timer_done
);

  import icb_pkg::*;

  wait_t cnt;     // Remaining wait states
  logic  active;  // Timing an access

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      active <= 1'b0;
      cnt    <= '0;
    end else if (timer_start) begin
      active <= 1'b1;
      cnt    <= MEM_WAIT;
    end else if (active) begin
      if (cnt == '0) active <= 1'b0;  // Done seen, stop
      else cnt <= cnt - 1'b1;
    end
  end

  // Zero wait states still give done one cycle after start
  assign timer_done = active & (cnt == '0);

endmodule
